// ==== rtl/muldiv_pkg.sv ====
package muldiv_pkg;

    // --------------------------------------------------
    // Operation encoding
    // --------------------------------------------------

    // Values follow the funct3 field of the RV64M register-register instructions
    typedef enum logic [2:0] {
        MUL    = 3'd0,  // Low half of the product
        MULH   = 3'd1,  // High half with both operands signed
        MULHSU = 3'd2,  // High half with a signed rs1 and an unsigned rs2
        MULHU  = 3'd3,  // High half with both operands unsigned
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    // --------------------------------------------------
    // Classification
    // --------------------------------------------------

    // Bit 2 of funct3 splits the divide group from the multiply group
    function automatic logic is_div_op(input muldiv_op_e op);
        return op[2];
    endfunction

endpackage

// ==== rtl/muldiv_issue.sv ====
`timescale 1ns/1ps

module muldiv_issue
    import muldiv_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            in_valid,
    input  muldiv_op_e      op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    input  logic            result_taken,
    output logic            in_ready,
    output logic            mul_start,
    output logic            div_start,
    output logic [XLEN-1:0] mag_a,
    output logic [XLEN-1:0] mag_b,
    output muldiv_op_e      op_q,
    output logic            neg_lo,
    output logic            neg_hi,
    output logic            div_zero,
    output logic            div_ovf,
    output logic [XLEN-1:0] dividend_q
);

    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic busy;
    logic accept;
    logic a_signed;
    logic b_signed;
    logic sign_a;
    logic sign_b;

    always_comb begin
        case (op)
            MULH, DIV, REM: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            MULHSU: begin
                a_signed = 1'b1;
                b_signed = 1'b0;
            end
            default: begin  // MUL keeps its low half whatever the signs
                a_signed = 1'b0;
                b_signed = 1'b0;
            end
        endcase
    end

    assign sign_a = a_signed & src1[XLEN-1];
    assign sign_b = b_signed & src2[XLEN-1];

    assign in_ready = !busy && !flush;  // Nothing enters while a redirect is in progress
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy      <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= accept && !is_div_op(op);
            div_start <= accept && is_div_op(op);
            if (accept)
                busy <= 1'b1;
            else if (result_taken)
                busy <= 1'b0;  // Result stage owns the value now
        end
    end

    // Operand payload stays put until the result stage has captured it
    always_ff @(posedge clk) begin
        if (accept) begin
            mag_a      <= sign_a ? -src1 : src1;
            mag_b      <= sign_b ? -src2 : src2;
            op_q       <= op;
            neg_lo     <= sign_a ^ sign_b;
            neg_hi     <= sign_a;  // Remainder takes the sign of the dividend
            div_zero   <= is_div_op(op) && (src2 == '0);
            div_ovf    <= (op == DIV || op == REM) && (src1 == MOST_NEG) && (src2 == '1);
            dividend_q <= src1;
        end
    end

endmodule

// ==== rtl/mul_iter.sv ====
`timescale 1ns/1ps

module mul_iter #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              start,
    input  logic              hold,
    input  logic [XLEN-1:0]   mag_a,
    input  logic [XLEN-1:0]   mag_b,
    output logic              done,
    output logic [2*XLEN-1:0] prod
);

    localparam int CW = $clog2(XLEN + 1);

    logic [2*XLEN-1:0] acc;  // Upper half sums, lower half still holds multiplier bits
    logic [XLEN-1:0]   mcand;
    logic              busy;
    logic [CW-1:0]     count;  // Steps already done
    logic              last;

    logic [2*XLEN-1:0] src;
    logic [XLEN-1:0]   mc;
    logic [XLEN:0]     sum;
    logic [2*XLEN-1:0] acc_next;

    // --------------------------------------------------
    // One shift-add step
    // --------------------------------------------------

    // The first step runs straight off the start operands so done lands after XLEN cycles
    assign src      = start ? {{XLEN{1'b0}}, mag_b} : acc;
    assign mc       = start ? mag_a : mcand;
    assign sum      = {1'b0, src[2*XLEN-1:XLEN]} + (src[0] ? {1'b0, mc} : {(XLEN+1){1'b0}});
    assign acc_next = {sum, src[XLEN-1:1]};

    assign last = busy && (count == CW'(XLEN));

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= CW'(1);
        end else if (busy && !last) begin
            count <= count + CW'(1);
        end else if (last && !hold) begin
            busy <= 1'b0;  // Result stage took the product
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc   <= acc_next;
            mcand <= mag_a;
        end else if (busy && !last) begin
            acc <= acc_next;
        end
    end

    assign done = last && !flush;
    assign prod = acc;

endmodule

// ==== rtl/div_iter.sv ====
`timescale 1ns/1ps

module div_iter #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            start,
    input  logic            hold,
    input  logic [XLEN-1:0] mag_a,
    input  logic [XLEN-1:0] mag_b,
    output logic            done,
    output logic [XLEN-1:0] quot,
    output logic [XLEN-1:0] rem
);

    localparam int CW = $clog2(XLEN + 1);

    // Partial remainder on top, dividend bits turning into quotient bits below
    logic [2*XLEN-1:0] pr;
    logic [XLEN-1:0]   divisor;
    logic              busy;
    logic [CW-1:0]     count;
    logic              last;

    logic [2*XLEN-1:0] src;
    logic [XLEN-1:0]   dvs;
    logic [XLEN+1:0]   diff;
    logic [2*XLEN-1:0] pr_next;

    // --------------------------------------------------
    // One restoring step
    // --------------------------------------------------

    assign src  = start ? {{XLEN{1'b0}}, mag_a} : pr;
    assign dvs  = start ? mag_b : divisor;
    assign diff = {1'b0, src[2*XLEN-1:XLEN-1]} - {2'b00, dvs};  // Trial subtract after the shift

    always_comb begin
        if (diff[XLEN+1])
            pr_next = {src[2*XLEN-2:0], 1'b0};  // Negative so keep the shifted remainder
        else
            pr_next = {diff[XLEN-1:0], src[XLEN-2:0], 1'b1};
    end

    assign last = busy && (count == CW'(XLEN));

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= CW'(1);
        end else if (busy && !last) begin
            count <= count + CW'(1);
        end else if (last && !hold) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pr      <= pr_next;
            divisor <= mag_b;
        end else if (busy && !last) begin
            pr <= pr_next;
        end
    end

    // A zero divisor never goes negative and leaves all ones over the dividend
    assign done = last && !flush;
    assign quot = pr[XLEN-1:0];
    assign rem  = pr[2*XLEN-1:XLEN];

endmodule

// ==== rtl/muldiv_result.sv ====
`timescale 1ns/1ps

module muldiv_result
    import muldiv_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  muldiv_op_e        op_q,
    input  logic              neg_lo,
    input  logic              neg_hi,
    input  logic              div_zero,
    input  logic              div_ovf,
    input  logic [XLEN-1:0]   dividend_q,
    input  logic              mul_done,
    input  logic [2*XLEN-1:0] prod,
    input  logic              div_done,
    input  logic [XLEN-1:0]   quot,
    input  logic [XLEN-1:0]   rem,
    input  logic              out_ready,
    output logic              hold,
    output logic              result_taken,
    output logic              out_valid,
    output logic [XLEN-1:0]   result
);

    logic [2*XLEN-1:0] prod_s;
    logic [XLEN-1:0]   quot_s;
    logic [XLEN-1:0]   rem_s;
    logic [XLEN-1:0]   res_next;

    // Buffer is free when empty or draining this cycle
    assign hold         = out_valid && !out_ready;
    assign result_taken = (mul_done || div_done) && !hold;

    // --------------------------------------------------
    // Sign restore and ISA special cases
    // --------------------------------------------------

    assign prod_s = neg_lo ? -prod : prod;  // Whole product negated so the high half borrows right
    assign quot_s = neg_lo ? -quot : quot;
    assign rem_s  = neg_hi ? -rem : rem;

    always_comb begin
        case (op_q)
            MUL:                 res_next = prod_s[XLEN-1:0];
            MULH, MULHSU, MULHU: res_next = prod_s[2*XLEN-1:XLEN];
            DIV, DIVU:           res_next = quot_s;
            default:             res_next = rem_s;
        endcase
        if (is_div_op(op_q)) begin
            if (div_zero)
                res_next = (op_q == DIV || op_q == DIVU) ? '1 : dividend_q;
            else if (div_ovf)
                res_next = (op_q == DIV) ? dividend_q : '0;  // Most negative over minus one
        end
    end

    // --------------------------------------------------
    // One-entry output buffer
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else if (result_taken)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (result_taken)
            result <= res_next;
    end

endmodule

// ==== rtl/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit
    import muldiv_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            in_valid,
    output logic            in_ready,
    input  muldiv_op_e      op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic            out_valid,
    input  logic            out_ready,
    output logic [XLEN-1:0] result
);

    // Issue to engines
    logic              mul_start;
    logic              div_start;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;

    // Issue to result stage
    muldiv_op_e        op_q;
    logic              neg_lo;
    logic              neg_hi;
    logic              div_zero;
    logic              div_ovf;
    logic [XLEN-1:0]   dividend_q;
    logic              result_taken;

    // Engines to result stage
    logic              hold;
    logic              mul_done;
    logic [2*XLEN-1:0] prod;
    logic              div_done;
    logic [XLEN-1:0]   quot;
    logic [XLEN-1:0]   rem;

    muldiv_issue #(.XLEN(XLEN)) u_issue (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .op(op), .src1(src1), .src2(src2),
        .result_taken(result_taken), .in_ready(in_ready),
        .mul_start(mul_start), .div_start(div_start), .mag_a(mag_a), .mag_b(mag_b),
        .op_q(op_q), .neg_lo(neg_lo), .neg_hi(neg_hi),
        .div_zero(div_zero), .div_ovf(div_ovf), .dividend_q(dividend_q)
    );

    mul_iter #(.XLEN(XLEN)) u_mul (
        .clk(clk), .rst(rst), .flush(flush),
        .start(mul_start), .hold(hold), .mag_a(mag_a), .mag_b(mag_b),
        .done(mul_done), .prod(prod)
    );

    div_iter #(.XLEN(XLEN)) u_div (
        .clk(clk), .rst(rst), .flush(flush),
        .start(div_start), .hold(hold), .mag_a(mag_a), .mag_b(mag_b),
        .done(div_done), .quot(quot), .rem(rem)
    );

    muldiv_result #(.XLEN(XLEN)) u_result (
        .clk(clk), .rst(rst),
        .op_q(op_q), .neg_lo(neg_lo), .neg_hi(neg_hi),
        .div_zero(div_zero), .div_ovf(div_ovf), .dividend_q(dividend_q),
        .mul_done(mul_done), .prod(prod), .div_done(div_done), .quot(quot), .rem(rem),
        .out_ready(out_ready), .hold(hold), .result_taken(result_taken),
        .out_valid(out_valid), .result(result)
    );

endmodule

// ==== sim/muldiv_model.svh ====
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// Expected RV64M result worked out from the ISA rules at 64 bits
// The including module imports muldiv_pkg for the operation names
function automatic logic [63:0] muldiv_model(input muldiv_op_e op,
                                             input logic [63:0] a,
                                             input logic [63:0] b);
    logic [127:0]       a_s;
    logic [127:0]       b_s;
    logic [127:0]       a_u;
    logic [127:0]       b_u;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic               ovf;

    a_s = {{64{a[63]}}, a};  // Sign extended so the low 128 product bits are exact
    b_s = {{64{b[63]}}, b};
    a_u = {64'd0, a};
    b_u = {64'd0, b};
    sa  = a;
    sb  = b;
    ovf = (a == 64'h8000_0000_0000_0000) && (b == '1);

    case (op)
        MUL:    return a_u[63:0] * b_u[63:0];
        MULH:   return 64'((a_s * b_s) >> 64);
        MULHSU: return 64'((a_s * b_u) >> 64);
        MULHU:  return 64'((a_u * b_u) >> 64);
        DIV: begin
            if (b == '0) return '1;
            if (ovf) return a;
            return sa / sb;
        end
        DIVU:   return (b == '0) ? '1 : a / b;
        REM: begin
            if (b == '0) return a;
            if (ovf) return '0;
            return sa % sb;
        end
        default: return (b == '0) ? a : a % b;
    endcase
endfunction

`endif

// ==== sim/muldiv_tb.sv ====
`timescale 1ns/1ps

module muldiv_tb
    import muldiv_pkg::*;
;

    `include "muldiv_model.svh"

    localparam int          XLEN          = 64;
    localparam int          RESET_CYCLES  = 16;
    localparam int          NUM_TESTS     = 600;
    localparam int          CORNER_TESTS  = 8 * 5 * 5;
    localparam int          FLUSH_TESTS   = 3;
    localparam int          RANDOM_TESTS  = NUM_TESTS - CORNER_TESTS - FLUSH_TESTS;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * (XLEN + 2) * 4 + RESET_CYCLES;
    localparam logic [31:0] SEED          = 32'h89e4cd24;
    localparam logic [63:0] MOST_NEG      = 64'h8000_0000_0000_0000;
    localparam logic [63:0] MOST_POS      = 64'h7fff_ffff_ffff_ffff;

    logic            clk;
    logic            rst;
    logic            flush;
    logic            in_valid;
    logic            in_ready;
    muldiv_op_e      op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            out_valid;
    logic            out_ready;
    logic [XLEN-1:0] result;

    logic [31:0]     rng_state;
    logic            ready_random;  // out_ready toggles at random
    logic            flush_random;  // Occasional flush pulses
    logic            force_stall;   // out_ready pinned low
    logic [63:0]     exp_q[$];      // Buffered result first, then the one in an engine
    logic            in_engine;
    int              engine_age;    // Edges since the operation was accepted
    logic            buffer_full;
    logic            stalled;
    logic [63:0]     held_result;
    logic            captured;
    logic            drained;
    logic            model_hold;
    int              error_count;
    int              accept_count;
    int              flush_count;
    int              result_count;
    int              cycle_count;

    muldiv_unit #(.XLEN(XLEN)) uut (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .in_ready(in_ready), .op(op), .src1(src1), .src2(src2),
        .out_valid(out_valid), .out_ready(out_ready), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [63:0] corner_value(input int idx);
        case (idx)
            0:       return 64'd0;
            1:       return 64'd1;
            2:       return '1;  // Minus one
            3:       return MOST_NEG;
            default: return MOST_POS;
        endcase
    endfunction

    // Mix of corners, small magnitudes of both signs and full-width words
    function automatic logic [63:0] pick_operand();
        logic [31:0] r;
        r = next_random();
        case (r[1:0])
            2'd0:    return corner_value(int'(r[4:2]) % 5);
            2'd1:    return {40'd0, r[31:8]};
            2'd2:    return -{40'd0, r[31:8]};
            default: return {next_random(), next_random()};
        endcase
    endfunction

    // Called on every falling edge to set the output side and the flush line
    task automatic drive_misc();
        logic [31:0] r;
        r = next_random();
        out_ready = force_stall ? 1'b0 : (ready_random ? r[0] : 1'b1);
        flush     = flush_random && (r[15:8] == 8'd0);  // About one cycle in 256
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        drive_misc();
    endtask

    // Presents one operation and keeps it up until the monitor sees it accepted
    task automatic send_op(input muldiv_op_e sel_op, input logic [63:0] a,
                           input logic [63:0] b);
        int start_count;
        @(negedge clk);
        in_valid    = 1'b1;
        op          = sel_op;
        src1        = a;
        src2        = b;
        drive_misc();
        start_count = accept_count;
        do begin
            @(negedge clk);
            drive_misc();
        end while (accept_count == start_count);
        in_valid = 1'b0;
    endtask

    // --------------------------------------------------
    // Monitor and scoreboard
    // --------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            in_engine   = 1'b0;
            engine_age  = 0;
            buffer_full = 1'b0;
            stalled     = 1'b0;
        end else begin
            assert (out_valid == buffer_full) else begin
                $display("Error: out_valid expected %h actual %h", buffer_full, out_valid);
                error_count = error_count + 1;
            end
            assert (in_ready == (!in_engine && !flush)) else begin
                $display("Error: in_ready expected %h actual %h", !in_engine && !flush, in_ready);
                error_count = error_count + 1;
            end
            if (stalled) begin
                assert (!out_valid || result == held_result) else begin
                    $display("Error: result expected %h actual %h while stalled",
                             held_result, result);
                    error_count = error_count + 1;
                end
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("A result was handed out with no operation outstanding");
                    error_count = error_count + 1;
                end
                if (exp_q.size() != 0) begin
                    assert (result == exp_q[0]) else begin
                        $display("Error: result expected %h actual %h", exp_q[0], result);
                        error_count = error_count + 1;
                    end
                    void'(exp_q.pop_front());
                end
                result_count = result_count + 1;
            end

            // Expected state after this edge
            model_hold = buffer_full && !out_ready;
            drained    = buffer_full && out_ready;
            captured   = 1'b0;
            if (in_engine) begin
                engine_age = engine_age + 1;
                if (flush) begin
                    void'(exp_q.pop_back());  // Dropped before the result stage took it
                    in_engine   = 1'b0;
                    flush_count = flush_count + 1;
                end else if (engine_age >= XLEN + 1 && !model_hold) begin
                    captured  = 1'b1;
                    in_engine = 1'b0;
                end
            end
            if (captured)
                buffer_full = 1'b1;
            else if (drained)
                buffer_full = 1'b0;
            if (in_valid && in_ready) begin
                exp_q.push_back(muldiv_model(op, src1, src2));
                in_engine    = 1'b1;
                engine_age   = 0;
                accept_count = accept_count + 1;
            end
            stalled     = out_valid && !out_ready;
            held_result = result;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        int          o;
        int          i;
        int          j;
        int          n;
        int          gap;
        logic [31:0] r;

        rst          = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        op           = MUL;
        src1         = '0;
        src2         = '0;
        out_ready    = 1'b1;
        rng_state    = SEED;
        ready_random = 1'b0;
        flush_random = 1'b0;
        force_stall  = 1'b0;
        error_count  = 0;
        accept_count = 0;
        flush_count  = 0;
        result_count = 0;
        cycle_count  = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Every corner pair on every operation with out_ready held high
        for (o = 0; o < 8; o++)
            for (i = 0; i < 5; i++)
                for (j = 0; j < 5; j++)
                    send_op(muldiv_op_e'(o[2:0]), corner_value(i), corner_value(j));

        // The last corner result has to leave before the output is stalled
        while (exp_q.size() != 0 || in_engine)
            idle_cycle();

        // A waiting result survives a flush of the operation behind it
        force_stall = 1'b1;
        send_op(MULHU, '1, '1);
        send_op(DIV, MOST_NEG, 64'd3);
        repeat (5) idle_cycle();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush       = 1'b0;
        force_stall = 1'b0;
        send_op(REM, -64'd7, 64'd2);

        ready_random = 1'b1;
        flush_random = 1'b1;
        for (n = 0; n < RANDOM_TESTS; n++) begin
            gap = next_random() % 3;
            repeat (gap) idle_cycle();
            r = next_random();
            send_op(muldiv_op_e'(r[2:0]), pick_operand(), pick_operand());
        end

        ready_random = 1'b0;
        flush_random = 1'b0;
        while (exp_q.size() != 0 || in_engine)
            idle_cycle();
        repeat (2) idle_cycle();

        $display("Errors: %0d  accepted: %0d  flushed: %0d  results: %0d",
                 error_count, accept_count, flush_count, result_count);
        if (error_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+sim
rtl/muldiv_pkg.sv
rtl/muldiv_issue.sv
rtl/mul_iter.sv
rtl/div_iter.sv
rtl/muldiv_result.sv
rtl/muldiv_unit.sv
sim/muldiv_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the muldiv testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module muldiv_tb -f project.f -o muldiv_sim

./obj_dir/muldiv_sim | tee sim.log

# The testbench exits normally either way, so the log decides
if grep -q "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
